//--- verilog/cascade_pkg.sv
package cascade_pkg;

    ////////////////////////////////////////////////////////////
    // image and datapath sizes
    ////////////////////////////////////////////////////////////

    localparam int II_WIDTH  = 160;
    localparam int II_HEIGHT = 120;

    localparam int ADDR_W = 15;                 // covers 160 * 120 words
    localparam int DATA_W = 21;                 // signed integral-image sample
    localparam int FEAT_W = 23;                 // room for the 2x corner weights

    localparam int NUM_STAGES = 4;
    localparam int CORNERS    = 6;              // horizontal two-rectangle

    typedef logic [1:0] stage_idx_t;
    typedef logic [2:0] corner_idx_t;

    ////////////////////////////////////////////////////////////
    // stage table
    ////////////////////////////////////////////////////////////

    localparam int WINDOW_X = 20;               // window starts 20 columns in

    localparam int STAGE_X0 [NUM_STAGES] = '{ 4, 43, 39,  0};   // left column
    localparam int STAGE_XM [NUM_STAGES] = '{41, 60, 51, 22};   // split column
    localparam int STAGE_X1 [NUM_STAGES] = '{78, 77, 63, 44};   // right column
    localparam int STAGE_Y0 [NUM_STAGES] = '{24, 30, 35, 19};   // top row
    localparam int STAGE_Y1 [NUM_STAGES] = '{36, 65, 57, 36};   // bottom row

    localparam logic signed [FEAT_W-1:0] STAGE_THRESH [NUM_STAGES] = '{
        23'sd0,
        -23'sd1500,
        23'sd800,
        23'sd2500
    };

    ////////////////////////////////////////////////////////////
    // threshold steering
    ////////////////////////////////////////////////////////////

    localparam int OFFSET_MIN  = -8;
    localparam int OFFSET_MAX  = 7;
    localparam int THRESH_STEP = 64;            // feature units per step

    typedef logic signed [3:0] offset_t;
    typedef logic signed [3:0] vote_cnt_t;      // -4 .. +4 over four stages

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,
        SEQ_DONE
    } seq_state_t;

    localparam int DETECT_LATENCY = 28;         // start edge to done pulse

endpackage

//--- verilog/corner_if.sv
`timescale 1ns/1ns

interface corner_if import cascade_pkg::*; ();

    logic                     valid;
    stage_idx_t               stage;
    corner_idx_t              corner;
    logic signed [DATA_W-1:0] value;    // memory read data, aligned with valid

    modport src (
        output valid,
        output stage,
        output corner,
        output value
    );

    modport dst (
        input valid,
        input stage,
        input corner,
        input value
    );

endinterface

//--- verilog/cascade_sequencer.sv
`timescale 1ns/1ns

module cascade_sequencer import cascade_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic detect_en,
    input  logic vote_valid,
    input  logic vote_pass,
    output logic start,
    output logic detect_done,
    output logic detected_flag
);

    seq_state_t state;
    logic       detect_en_q;
    vote_cnt_t  vote_total;
    vote_cnt_t  vote_total_nxt;
    stage_idx_t vote_count;

    assign vote_total_nxt = vote_pass ? vote_total + vote_cnt_t'(1)
                                      : vote_total - vote_cnt_t'(1);

    assign detect_done = (state == SEQ_DONE);   // one cycle, DONE always exits

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= SEQ_IDLE;
            detect_en_q   <= 1'b0;
            start         <= 1'b0;
            detected_flag <= 1'b0;
            vote_total    <= '0;
            vote_count    <= '0;
        end else begin
            detect_en_q <= detect_en;
            start       <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (detect_en && !detect_en_q) begin
                        start      <= 1'b1;     // kicks the fetcher
                        vote_total <= '0;
                        vote_count <= '0;
                        state      <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (vote_valid) begin
                        vote_total <= vote_total_nxt;
                        vote_count <= vote_count + 1'b1;
                        if (vote_count == stage_idx_t'(NUM_STAGES - 1)) begin
                            detected_flag <= (vote_total_nxt >= 0);  // tie counts as hit
                            state         <= SEQ_DONE;
                        end
                    end
                end
                default: state <= SEQ_IDLE;     // SEQ_DONE
            endcase
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (rst)
        detect_done |=> !detect_done);

    // start leaves at cycle 1, done must land at cycle DETECT_LATENCY
    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(start) |-> ##(DETECT_LATENCY - 1) $rose(detect_done));

endmodule

//--- verilog/corner_fetcher.sv
`timescale 1ns/1ns

module corner_fetcher import cascade_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic signed [DATA_W-1:0] data_in,
    output logic [ADDR_W-1:0]        rd_addr,
    corner_if.src                    cif
);

    logic        active;
    stage_idx_t  stage_cnt;
    corner_idx_t corner_cnt;

    ////////////////////////////////////////////////////////////
    // stage / corner walk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            stage_cnt  <= '0;
            corner_cnt <= '0;
        end else if (start) begin
            active     <= 1'b1;
            stage_cnt  <= '0;
            corner_cnt <= '0;
        end else if (active) begin
            if (corner_cnt == corner_idx_t'(CORNERS - 1)) begin
                corner_cnt <= '0;
                stage_cnt  <= stage_cnt + 1'b1;
                if (stage_cnt == stage_idx_t'(NUM_STAGES - 1))
                    active <= 1'b0;             // all 24 corners issued
            end else begin
                corner_cnt <= corner_cnt + 1'b1;
            end
        end
    end

    // corner order: (XM,Y1) (XM,Y0) (X0,Y1) (X0,Y0) (X1,Y1) (X1,Y0)
    always_comb begin
        int x;
        int y;
        case (corner_cnt[2:1])
            2'd0:    x = STAGE_XM[stage_cnt];
            2'd1:    x = STAGE_X0[stage_cnt];
            default: x = STAGE_X1[stage_cnt];
        endcase
        y = corner_cnt[0] ? STAGE_Y0[stage_cnt] : STAGE_Y1[stage_cnt];
        rd_addr = active ? ADDR_W'(x + WINDOW_X + y * II_WIDTH) : '0;
    end

    ////////////////////////////////////////////////////////////
    // align tags with the one-cycle memory read
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst)
            cif.valid <= 1'b0;
        else
            cif.valid <= active;
    end

    always_ff @(posedge clk) begin
        cif.stage  <= stage_cnt;                // tag only, qualified by valid
        cif.corner <= corner_cnt;
    end

    assign cif.value = data_in;

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        active |-> (int'(rd_addr) < II_WIDTH * II_HEIGHT));

endmodule

//--- verilog/threshold_tuner.sv
`timescale 1ns/1ns

module threshold_tuner import cascade_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    increment_threshold,
    input  logic    decrement_threshold,
    output offset_t offset
);

    logic inc_q;
    logic dec_q;
    logic inc_rise;
    logic dec_rise;

    assign inc_rise = increment_threshold && !inc_q;
    assign dec_rise = decrement_threshold && !dec_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            inc_q  <= 1'b0;
            dec_q  <= 1'b0;
            offset <= '0;
        end else begin
            inc_q <= increment_threshold;
            dec_q <= decrement_threshold;
            // simultaneous edges cancel out
            if (inc_rise && !dec_rise && offset != offset_t'(OFFSET_MAX))
                offset <= offset + offset_t'(1);
            else if (dec_rise && !inc_rise && offset != offset_t'(OFFSET_MIN))
                offset <= offset - offset_t'(1);    // saturates at the floor
        end
    end

    // a wrap past either limit shows up as a jump of 15
    a_offset_range: assert property (@(posedge clk) disable iff (rst)
        (int'(offset) - int'($past(offset))) inside {-1, 0, 1});

endmodule

//--- verilog/feature_evaluator.sv
`timescale 1ns/1ns

module feature_evaluator import cascade_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    corner_if.dst   cif,
    input  offset_t offset,
    output logic    vote_valid,
    output logic    vote_pass
);

    logic signed [FEAT_W-1:0] acc;
    logic signed [FEAT_W-1:0] value_ext;
    logic signed [FEAT_W-1:0] term;
    logic signed [FEAT_W-1:0] feature;
    logic signed [FEAT_W-1:0] offset_scaled;
    logic signed [FEAT_W-1:0] threshold;

    assign value_ext = FEAT_W'(cif.value);      // sign extend

    ////////////////////////////////////////////////////////////
    // left minus right, folded into per-corner weights
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cif.corner)
            3'd0:    term = value_ext <<< 1;        // +2, shared edge
            3'd1:    term = -(value_ext <<< 1);     // -2, shared edge
            3'd2:    term = -value_ext;
            3'd3:    term = value_ext;
            3'd4:    term = -value_ext;
            3'd5:    term = value_ext;
            default: term = '0;
        endcase
    end

    assign feature       = acc + term;
    assign offset_scaled = FEAT_W'(offset) * FEAT_W'(THRESH_STEP);
    assign threshold     = STAGE_THRESH[cif.stage] + offset_scaled;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc        <= '0;
            vote_valid <= 1'b0;
            vote_pass  <= 1'b0;
        end else begin
            vote_valid <= 1'b0;
            if (cif.valid) begin
                if (cif.corner == corner_idx_t'(CORNERS - 1)) begin
                    vote_valid <= 1'b1;         // one vote per stage
                    vote_pass  <= (feature >= threshold);
                    acc        <= '0;
                end else begin
                    acc <= feature;
                end
            end
        end
    end

    // stream must start on a stage boundary or the accumulator mixes stages
    a_stream_aligned: assert property (@(posedge clk) disable iff (rst)
        (cif.valid && !$past(cif.valid)) |-> (cif.corner == '0));

endmodule

//--- verilog/cascade_top.sv
`timescale 1ns/1ns

module cascade_top import cascade_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     detect_en,
    input  logic                     increment_threshold,
    input  logic                     decrement_threshold,
    input  logic signed [DATA_W-1:0] data_in,
    output logic [ADDR_W-1:0]        rd_addr,
    output logic                     detect_done,
    output logic                     detected_flag
);

    logic    start;
    logic    vote_valid;
    logic    vote_pass;
    offset_t offset;

    corner_if u_corner_if ();

    cascade_sequencer u_cascade_sequencer (
        .clk           (clk),
        .rst           (rst),
        .detect_en     (detect_en),
        .vote_valid    (vote_valid),
        .vote_pass     (vote_pass),
        .start         (start),
        .detect_done   (detect_done),
        .detected_flag (detected_flag)
    );

    corner_fetcher u_corner_fetcher (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .data_in (data_in),
        .rd_addr (rd_addr),
        .cif     (u_corner_if)
    );

    threshold_tuner u_threshold_tuner (
        .clk                 (clk),
        .rst                 (rst),
        .increment_threshold (increment_threshold),
        .decrement_threshold (decrement_threshold),
        .offset              (offset)
    );

    feature_evaluator u_feature_evaluator (
        .clk        (clk),
        .rst        (rst),
        .cif        (u_corner_if),
        .offset     (offset),
        .vote_valid (vote_valid),
        .vote_pass  (vote_pass)
    );

endmodule

//--- tests/tb_cascade.sv
`timescale 1ns/1ns

module tb_cascade import cascade_pkg::*; ();

    localparam int MEM_WORDS       = II_WIDTH * II_HEIGHT;
    localparam int LAST_ADDR_CYCLE = 1 + NUM_STAGES * CORNERS;
    localparam int RUN_CYCLES      = DETECT_LATENCY + 4;    // a few idle cycles after done
    localparam int CYCLE_LIMIT     = 40 * 40 + 10;

    logic                     clk;
    logic                     rst;
    logic                     detect_en;
    logic                     increment_threshold;
    logic                     decrement_threshold;
    logic signed [DATA_W-1:0] data_in;
    logic [ADDR_W-1:0]        rd_addr;
    logic                     detect_done;
    logic                     detected_flag;

    logic signed [DATA_W-1:0] mem [MEM_WORDS];
    logic [ADDR_W-1:0]        addr_q = '0;
    int                       offset_model;
    int                       errors;
    int                       checks;
    int                       cycles = 0;

    cascade_top u_cascade_top (
        .clk                 (clk),
        .rst                 (rst),
        .detect_en           (detect_en),
        .increment_threshold (increment_threshold),
        .decrement_threshold (decrement_threshold),
        .data_in             (data_in),
        .rd_addr             (rd_addr),
        .detect_done         (detect_done),
        .detected_flag       (detected_flag)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // synchronous read with data one cycle after the address
    always @(negedge clk) begin
        data_in <= mem[addr_q];
        addr_q  <= rd_addr;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int corner_addr(int s, int c);
        int x;
        int y;
        x = (c < 2) ? STAGE_XM[s] : (c < 4) ? STAGE_X0[s] : STAGE_X1[s];
        y = (c % 2 == 0) ? STAGE_Y1[s] : STAGE_Y0[s];
        return x + WINDOW_X + y * II_WIDTH;
    endfunction

    function automatic int ii_at(int x, int y);
        return int'(mem[x + WINDOW_X + y * II_WIDTH]);
    endfunction

    // rectangle sums straight from the integral image
    function automatic int stage_feature(int s);
        int left;
        int right;
        left  = ii_at(STAGE_XM[s], STAGE_Y1[s]) - ii_at(STAGE_XM[s], STAGE_Y0[s])
              - ii_at(STAGE_X0[s], STAGE_Y1[s]) + ii_at(STAGE_X0[s], STAGE_Y0[s]);
        right = ii_at(STAGE_X1[s], STAGE_Y1[s]) - ii_at(STAGE_X1[s], STAGE_Y0[s])
              - ii_at(STAGE_XM[s], STAGE_Y1[s]) + ii_at(STAGE_XM[s], STAGE_Y0[s]);
        return left - right;
    endfunction

    function automatic logic expected_flag();
        int passes;
        passes = 0;
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (stage_feature(s) >= int'(STAGE_THRESH[s]) + offset_model * THRESH_STEP)
                passes++;
        end
        return (2 * passes >= NUM_STAGES);     // tie is a detection
    endfunction

    ////////////////////////////////////////////////////////////
    // checks and stimulus
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(string name, int got, int exp);
        errors++;
        $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
    endtask

    task automatic check_value(string name, int got, int exp);
        checks++;
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    task automatic fill_random();
        foreach (mem[a])
            mem[a] = DATA_W'(int'($urandom % 32'd524288) - 262144);    // keeps features in range
    endtask

    task automatic set_stage_feature(int s, int feature);
        for (int c = 0; c < CORNERS; c++)
            mem[corner_addr(s, c)] = '0;
        mem[corner_addr(s, 0)] = DATA_W'(feature / 2);  // (XM,Y1) counts in both halves
    endtask

    task automatic pulse_tuner(logic inc, logic dec);
        @(negedge clk);
        increment_threshold = inc;
        decrement_threshold = dec;
        @(negedge clk);
        increment_threshold = 1'b0;
        decrement_threshold = 1'b0;
        if (inc && !dec && offset_model < OFFSET_MAX)
            offset_model++;
        if (dec && !inc && offset_model > OFFSET_MIN)
            offset_model--;
        check_value("offset", int'(u_cascade_top.offset), offset_model);
        check_value("rd_addr", int'(rd_addr), 0);
        check_value("detect_done", int'(detect_done), 0);
    endtask

    task automatic run_detect();
        int   exp_addr;
        logic exp_flag;
        exp_flag = expected_flag();
        @(negedge clk);
        detect_en = 1'b1;
        for (int label = 1; label <= RUN_CYCLES; label++) begin
            @(negedge clk);
            exp_addr = 0;
            if (label >= 2 && label <= LAST_ADDR_CYCLE)
                exp_addr = corner_addr((label - 2) / CORNERS, (label - 2) % CORNERS);
            check_value("rd_addr", int'(rd_addr), exp_addr);
            check_value("detect_done", int'(detect_done), int'(label == DETECT_LATENCY));
            if (label == DETECT_LATENCY)
                check_value("detected_flag", int'(detected_flag), int'(exp_flag));
            if (label == 4)
                detect_en = 1'b0;
            if (label == 8)
                detect_en = 1'b1;               // second edge mid run is ignored
        end
        detect_en = 1'b0;
    endtask

    initial begin
        rst                 = 1'b1;
        detect_en           = 1'b0;
        increment_threshold = 1'b0;
        decrement_threshold = 1'b0;
        data_in             = '0;
        offset_model        = 0;
        errors              = 0;
        checks              = 0;
        void'($urandom(32'h68642b5d));
        fill_random();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("rd_addr", int'(rd_addr), 0);
        check_value("detect_done", int'(detect_done), 0);
        check_value("detected_flag", int'(detected_flag), 0);
        check_value("offset", int'(u_cascade_top.offset), 0);

        repeat (3) begin
            fill_random();
            run_detect();
        end

        for (int s = 0; s < NUM_STAGES; s++)
            set_stage_feature(s, 100000);       // every stage passes
        run_detect();
        for (int s = 0; s < NUM_STAGES; s++)
            set_stage_feature(s, (s < NUM_STAGES / 2) ? 100000 : -100000);
        run_detect();

        // features sit 200 above each threshold
        for (int s = 0; s < NUM_STAGES; s++)
            set_stage_feature(s, int'(STAGE_THRESH[s]) + 200);
        run_detect();
        repeat (9) pulse_tuner(1'b1, 1'b0);     // saturates at the top
        run_detect();
        repeat (17) pulse_tuner(1'b0, 1'b1);    // saturates at the bottom
        run_detect();
        repeat (11) pulse_tuner(1'b1, 1'b0);
        pulse_tuner(1'b1, 1'b1);                // opposite edges leave the offset alone
        run_detect();
        pulse_tuner(1'b1, 1'b0);                // 4 steps lifts threshold past the feature
        run_detect();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- compile.f
verilog/cascade_pkg.sv
verilog/corner_if.sv
verilog/cascade_sequencer.sv
verilog/corner_fetcher.sv
verilog/threshold_tuner.sv
verilog/feature_evaluator.sv
verilog/cascade_top.sv
tests/tb_cascade.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP   = tb_cascade
FLIST = compile.f
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	cat $(LOG)
	! grep -q "TEST FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
